//--- verilog/shell_pkg.sv
package shell_pkg;

	// Color channel as delivered by the core
	typedef logic [7:0] color_t;

	// Reduced color channel on the board VGA pins
	typedef logic [5:0] vga_t;

	// Unsigned audio sample, midscale is silence
	typedef logic [15:0] audio_t;

	// Player vector, bit 7 down to 0
	// fire D, fire C, fire B, fire A, up, down, left, right
	typedef logic [7:0] joy_t;

	// Console keys one to four, key one in bit 0
	typedef logic [3:0] keys_t;

	// Scanline strength
	// 0 off, 1 25 %, 2 50 %, 3 75 %
	typedef logic [1:0] scan_t;

	// Download stream and cartridge byte
	typedef logic [7:0] byte_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		ST_WAIT_LOCK,   // PLL not yet locked
		ST_HOLD,        // Reset stretch running
		ST_LOAD,        // Cartridge download in progress
		ST_RUN          // Core released
	} ctrl_state_t;

endpackage

//--- verilog/shell_ctrl.sv
`timescale 1ns/1ns

module shell_ctrl import shell_pkg::*; #(
	parameter int RESET_HOLD = 16
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic pll_locked,
	input  logic reset_req,
	input  logic ioctl_download,
	output logic core_reset,
	output logic led
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	ctrl_state_t      state;
	ctrl_state_t      state_nxt;
	logic [CNT_W-1:0] hold_cnt;
	logic [CNT_W-1:0] hold_cnt_nxt;

	// Lock loss and downloads override everything, reset_req restarts the stretch
	always_comb begin
		state_nxt = state;
		hold_cnt_nxt = hold_cnt;
		if (!pll_locked) begin
			state_nxt = ST_WAIT_LOCK;
		end else if (ioctl_download) begin
			state_nxt = ST_LOAD;
		end else if (reset_req) begin
			state_nxt = ST_HOLD;
			hold_cnt_nxt = '0;
		end else begin
			case (state)
				ST_WAIT_LOCK, ST_LOAD: begin
					state_nxt = ST_HOLD;
					hold_cnt_nxt = '0;
				end
				ST_HOLD: begin
					if (hold_cnt == CNT_W'(RESET_HOLD - 1))
						state_nxt = ST_RUN;
					else
						hold_cnt_nxt = hold_cnt + 1'b1;
				end
				default: ;   // ST_RUN stays
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_WAIT_LOCK;
			hold_cnt <= '0;
			led <= 1'b1;
		end else begin
			state <= state_nxt;
			hold_cnt <= hold_cnt_nxt;
			led <= ~ioctl_download;   // Dark while loading
		end
	end

	assign core_reset = (state != ST_RUN);

	// Core never runs on an unlocked PLL
	a_reset_on_unlock: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!pll_locked |-> core_reset);

endmodule

//--- verilog/cart_loader.sv
`timescale 1ns/1ns

module cart_loader import shell_pkg::*; #(
	parameter int    ADDR_W     = 10,
	parameter byte_t CART_INDEX = 8'd0
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  byte_t             ioctl_index,
	input  logic [24:0]       ioctl_addr,
	input  byte_t             ioctl_dout,
	input  logic [ADDR_W-1:0] cart_addr,
	output logic              ioctl_wait,
	output byte_t             cart_data,
	output logic [ADDR_W:0]   cart_size
);

	byte_t           mem [2**ADDR_W];
	logic            strobe;
	logic            addr_fits;
	logic            wr_en;
	logic [ADDR_W:0] addr_p1;
	logic [ADDR_W:0] size_base;
	logic            dl_q;

	assign strobe = ioctl_wr & ~ioctl_wait;   // Strobes during wait are dropped
	assign addr_fits = (ioctl_addr >> ADDR_W) == 25'd0;
	assign wr_en = strobe & addr_fits & (ioctl_index == CART_INDEX);
	assign addr_p1 = {1'b0, ioctl_addr[ADDR_W-1:0]} + 1'b1;

	// New download starts the size count from zero
	assign size_base = (ioctl_download & ~dl_q) ? '0 : cart_size;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_wait <= 1'b0;
			dl_q <= 1'b0;
			cart_size <= '0;
		end else begin
			ioctl_wait <= strobe;   // One cycle of back-pressure per accepted strobe
			dl_q <= ioctl_download;
			if (wr_en && addr_p1 > size_base)
				cart_size <= addr_p1;
			else
				cart_size <= size_base;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[ioctl_addr[ADDR_W-1:0]] <= ioctl_dout;
		cart_data <= mem[cart_addr];   // Core read port
	end

	// Sender has to honour the wait flag
	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr);

endmodule

//--- verilog/input_mapper.sv
`timescale 1ns/1ns

module input_mapper import shell_pkg::*; (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [31:0] joystick_0,
	input  logic [31:0] joystick_1,
	input  logic        joyswap,
	output joy_t        joy_a,
	output joy_t        joy_b,
	output keys_t       keys
);

	joy_t  src_a;
	joy_t  src_b;
	keys_t keys_nxt;

	// Low byte carries directions and fire buttons
	always_comb begin
		if (joyswap) begin
			src_a = joystick_1[7:0];
			src_b = joystick_0[7:0];
		end else begin
			src_a = joystick_0[7:0];
			src_b = joystick_1[7:0];
		end
	end

	// Either pad can press the console keys
	assign keys_nxt = joystick_0[11:8] | joystick_1[11:8];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joy_a <= '0;
			joy_b <= '0;
			keys <= '0;
		end else begin
			joy_a <= src_a;
			joy_b <= src_b;
			keys <= keys_nxt;
		end
	end

endmodule

//--- verilog/scanline_video.sv
`timescale 1ns/1ns

module scanline_video import shell_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,
	input  color_t r,
	input  color_t g,
	input  color_t b,
	input  logic   hs,
	input  logic   vs,
	input  logic   de,
	input  scan_t  scanlines,
	output vga_t   vga_r,
	output vga_t   vga_g,
	output vga_t   vga_b,
	output logic   vga_hs,
	output logic   vga_vs
);

	logic odd_line;
	logic hs_rise;
	logic vs_rise;

	// Depth reduction, then dimming on odd lines
	function automatic vga_t shade(input color_t c, input scan_t s, input logic odd);
		vga_t v;
		v = c[7:2];
		if (odd) begin
			case (s)
				2'd1: v = v - (v >> 2);   // 25 %
				2'd2: v = v >> 1;         // 50 %
				2'd3: v = v >> 2;         // 75 %
				default: ;
			endcase
		end
		return v;
	endfunction

	// Delayed syncs double as edge detectors
	assign hs_rise = hs & ~vga_hs;
	assign vs_rise = vs & ~vga_vs;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			odd_line <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			if (vs_rise)
				odd_line <= 1'b0;   // Frame starts on an even line
			else if (hs_rise)
				odd_line <= ~odd_line;
			vga_hs <= hs;
			vga_vs <= vs;
			vga_r <= de ? shade(r, scanlines, odd_line) : '0;
			vga_g <= de ? shade(g, scanlines, odd_line) : '0;
			vga_b <= de ? shade(b, scanlines, odd_line) : '0;
		end
	end

endmodule

//--- verilog/sigma_delta_dac.sv
`timescale 1ns/1ns

module sigma_delta_dac import shell_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,
	input  audio_t audio,
	output logic   audio_out
);

	// Bit 16 holds the carry of the last addition
	logic [16:0] acc;

	// First order loop, the residue stays in the low 16 bits
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[15:0]} + {1'b0, audio};
	end

	// Pulse density follows audio / 65536
	assign audio_out = acc[16];

endmodule

//--- verilog/console_shell.sv
`timescale 1ns/1ns

module console_shell import shell_pkg::*; #(
	parameter int    ADDR_W     = 10,
	parameter int    RESET_HOLD = 16,
	parameter byte_t CART_INDEX = 8'd0
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	// Control
	input  logic              pll_locked,
	input  logic              reset_req,
	output logic              core_reset,
	output logic              led,
	// Cartridge download and core read port
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  byte_t             ioctl_index,
	input  logic [24:0]       ioctl_addr,
	input  byte_t             ioctl_dout,
	output logic              ioctl_wait,
	input  logic [ADDR_W-1:0] cart_addr,
	output byte_t             cart_data,
	output logic [ADDR_W:0]   cart_size,
	// Joysticks
	input  logic [31:0]       joystick_0,
	input  logic [31:0]       joystick_1,
	input  logic              joyswap,
	output joy_t              joy_a,
	output joy_t              joy_b,
	output keys_t             keys,
	// Video
	input  color_t            r,
	input  color_t            g,
	input  color_t            b,
	input  logic              hs,
	input  logic              vs,
	input  logic              de,
	input  scan_t             scanlines,
	output vga_t              vga_r,
	output vga_t              vga_g,
	output vga_t              vga_b,
	output logic              vga_hs,
	output logic              vga_vs,
	// Audio
	input  audio_t            audio,
	output logic              audio_out
);

	shell_ctrl #(
		.RESET_HOLD (RESET_HOLD)
	) u_ctrl (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.pll_locked     (pll_locked),
		.reset_req      (reset_req),
		.ioctl_download (ioctl_download),
		.core_reset     (core_reset),
		.led            (led)
	);

	cart_loader #(
		.ADDR_W     (ADDR_W),
		.CART_INDEX (CART_INDEX)
	) u_cart (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cart_addr      (cart_addr),
		.ioctl_wait     (ioctl_wait),
		.cart_data      (cart_data),
		.cart_size      (cart_size)
	);

	input_mapper u_inputs (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joyswap    (joyswap),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.keys       (keys)
	);

	scanline_video u_video (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.r         (r),
		.g         (g),
		.b         (b),
		.hs        (hs),
		.vs        (vs),
		.de        (de),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac u_dac (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.audio     (audio),
		.audio_out (audio_out)
	);

endmodule

//--- verif/console_shell_tb.sv
`timescale 1ns/1ns

module console_shell_tb import shell_pkg::*; ();

	localparam int    ADDR_W         = 10;
	localparam int    RESET_HOLD     = 16;
	localparam byte_t CART_INDEX     = 8'd0;
	localparam int    TIMEOUT_CYCLES = 6000;
	localparam int    N_WRITES       = 40;

	logic              clk_sys;
	logic              arst_n;
	logic              pll_locked;
	logic              reset_req;
	logic              core_reset;
	logic              led;
	logic              ioctl_download;
	logic              ioctl_wr;
	byte_t             ioctl_index;
	logic [24:0]       ioctl_addr;
	byte_t             ioctl_dout;
	logic              ioctl_wait;
	logic [ADDR_W-1:0] cart_addr;
	byte_t             cart_data;
	logic [ADDR_W:0]   cart_size;
	logic [31:0]       joystick_0;
	logic [31:0]       joystick_1;
	logic              joyswap;
	joy_t              joy_a;
	joy_t              joy_b;
	keys_t             keys;
	color_t            r;
	color_t            g;
	color_t            b;
	logic              hs;
	logic              vs;
	logic              de;
	scan_t             scanlines;
	vga_t              vga_r;
	vga_t              vga_g;
	vga_t              vga_b;
	logic              vga_hs;
	logic              vga_vs;
	audio_t            audio;
	logic              audio_out;

	int                errors = 0;
	int                cycles = 0;
	int                bytes_sent = 0;
	int                reads_done = 0;
	int                max_addr = -1;
	logic [31:0]       rng;
	byte_t             model [2**ADDR_W];   // Expected cartridge contents
	logic [ADDR_W-1:0] written [$];

	// Reference state, updated on the same edges as the DUT
	int                exp_hold;
	logic              exp_led;
	logic              exp_wait;
	joy_t              exp_a;
	joy_t              exp_b;
	keys_t             exp_keys;
	logic              hs_q;
	logic              vs_q;
	logic              line_odd;
	vga_t              exp_r;
	vga_t              exp_g;
	vga_t              exp_b_ch;
	logic              exp_hs;
	logic              exp_vs;
	logic              rd_req;
	logic              rd_valid;
	byte_t             rd_want;
	byte_t             rd_exp;
	logic              size_check;
	logic [ADDR_W:0]   exp_size;
	int                dac_cnt;
	int                dac_ones;

	console_shell #(
		.ADDR_W     (ADDR_W),
		.RESET_HOLD (RESET_HOLD),
		.CART_INDEX (CART_INDEX)
	) dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cycles <= cycles + 1;

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Top 6 bits, then the scanline strength on odd lines
	function automatic vga_t dim_channel(input color_t c, input scan_t s, input logic odd);
		vga_t v;
		v = c[7:2];
		if (odd && s == 2'd1)
			v = v - (v >> 2);
		else if (odd && s == 2'd2)
			v = v >> 1;
		else if (odd && s == 2'd3)
			v = v >> 2;
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("Summary: %0d errors, %0d bytes sent, %0d reads checked, %0d cycles",
			errors, bytes_sent, reads_done, cycles);
	endtask

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			exp_hold <= RESET_HOLD + 1;
			exp_led <= 1'b1;
			exp_wait <= 1'b0;
			rd_valid <= 1'b0;
			rd_exp <= '0;
		end else begin
			if (!pll_locked || ioctl_download)
				exp_hold <= RESET_HOLD + 1;   // One extra edge to enter the stretch
			else if (reset_req)
				exp_hold <= RESET_HOLD;
			else if (exp_hold != 0)
				exp_hold <= exp_hold - 1;
			exp_led <= ~ioctl_download;
			exp_wait <= ioctl_wr & ~exp_wait;
			rd_valid <= rd_req;
			rd_exp <= rd_want;
		end
	end

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			exp_a <= '0;
			exp_b <= '0;
			exp_keys <= '0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			line_odd <= 1'b0;
			exp_r <= '0;
			exp_g <= '0;
			exp_b_ch <= '0;
			exp_hs <= 1'b0;
			exp_vs <= 1'b0;
		end else begin
			exp_a <= joyswap ? joystick_1[7:0] : joystick_0[7:0];
			exp_b <= joyswap ? joystick_0[7:0] : joystick_1[7:0];
			exp_keys <= joystick_0[11:8] | joystick_1[11:8];
			hs_q <= hs;
			vs_q <= vs;
			if (vs && !vs_q)
				line_odd <= 1'b0;
			else if (hs && !hs_q)
				line_odd <= ~line_odd;
			exp_r <= de ? dim_channel(r, scanlines, line_odd) : '0;
			exp_g <= de ? dim_channel(g, scanlines, line_odd) : '0;
			exp_b_ch <= de ? dim_channel(b, scanlines, line_odd) : '0;
			exp_hs <= hs;
			exp_vs <= vs;
		end
	end

	// Ones on audio_out over the first 1024 output cycles
	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dac_cnt <= 0;
			dac_ones <= 0;
		end else begin
			if (dac_cnt < 2000)
				dac_cnt <= dac_cnt + 1;
			if (dac_cnt >= 1 && dac_cnt <= 1024 && audio_out)
				dac_ones <= dac_ones + 1;
		end
	end

	a_core_reset: assert property (@(posedge clk_sys) disable iff (!arst_n)
		core_reset == (exp_hold != 0))
		else report_mismatch("core_reset", $sampled(core_reset), $sampled(exp_hold != 0));
	a_led: assert property (@(posedge clk_sys) disable iff (!arst_n) led == exp_led)
		else report_mismatch("led", $sampled(led), $sampled(exp_led));
	a_load_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_download |=> core_reset && !led)
		else report_problem("core_reset or led released during the download");
	a_wait: assert property (@(posedge clk_sys) disable iff (!arst_n) ioctl_wait == exp_wait)
		else report_mismatch("ioctl_wait", $sampled(ioctl_wait), $sampled(exp_wait));
	a_read: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rd_valid |-> cart_data == rd_exp)
		else report_mismatch("cart_data", $sampled(cart_data), $sampled(rd_exp));
	a_size: assert property (@(posedge clk_sys) disable iff (!arst_n)
		size_check |-> cart_size == exp_size)
		else report_mismatch("cart_size", $sampled(cart_size), $sampled(exp_size));
	a_joy_a: assert property (@(posedge clk_sys) disable iff (!arst_n) joy_a == exp_a)
		else report_mismatch("joy_a", $sampled(joy_a), $sampled(exp_a));
	a_joy_b: assert property (@(posedge clk_sys) disable iff (!arst_n) joy_b == exp_b)
		else report_mismatch("joy_b", $sampled(joy_b), $sampled(exp_b));
	a_keys: assert property (@(posedge clk_sys) disable iff (!arst_n) keys == exp_keys)
		else report_mismatch("keys", $sampled(keys), $sampled(exp_keys));
	a_vga_r: assert property (@(posedge clk_sys) disable iff (!arst_n) vga_r == exp_r)
		else report_mismatch("vga_r", $sampled(vga_r), $sampled(exp_r));
	a_vga_g: assert property (@(posedge clk_sys) disable iff (!arst_n) vga_g == exp_g)
		else report_mismatch("vga_g", $sampled(vga_g), $sampled(exp_g));
	a_vga_b: assert property (@(posedge clk_sys) disable iff (!arst_n) vga_b == exp_b_ch)
		else report_mismatch("vga_b", $sampled(vga_b), $sampled(exp_b_ch));
	a_vga_sync: assert property (@(posedge clk_sys) disable iff (!arst_n)
		{vga_hs, vga_vs} == {exp_hs, exp_vs})
		else report_mismatch("vga_hs/vga_vs", $sampled({vga_hs, vga_vs}),
			$sampled({exp_hs, exp_vs}));
	a_dac: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dac_cnt == 1025 |-> dac_ones == 256)
		else report_mismatch("audio_out ones", $sampled(dac_ones), 256);

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic wait_core_run();
		do @(posedge clk_sys); while (core_reset);
	endtask

	// One strobe, then hold off until the wait flag has dropped
	task automatic send_byte(input byte_t idx, input logic [24:0] addr, input byte_t data);
		ioctl_index <= idx;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		do @(posedge clk_sys); while (ioctl_wait);
		bytes_sent++;
	endtask

	task automatic load_cart();
		logic [31:0]       rnd;
		logic [ADDR_W-1:0] a;
		ioctl_download <= 1'b1;
		@(posedge clk_sys);
		for (int i = 0; i < N_WRITES; i++) begin
			rnd = next_random();
			a = rnd[ADDR_W-1:0] % (2**ADDR_W - 1);   // Top address left free
			model[a] = rnd[31:24];
			written.push_back(a);
			if (int'(a) > max_addr)
				max_addr = a;
			send_byte(CART_INDEX, 25'(a), rnd[31:24]);
		end
		// Other index and an address beyond the cartridge must leave no trace
		for (int i = 0; i < 8; i++)
			send_byte(CART_INDEX + 8'd1, 25'(written[i]), ~model[written[i]]);
		send_byte(CART_INDEX + 8'd1, 25'(2**ADDR_W - 1), 8'h5a);
		send_byte(CART_INDEX, 25'(2**ADDR_W) + 25'(written[0]), ~model[written[0]]);
		ioctl_download <= 1'b0;
		exp_size <= (ADDR_W+1)'(max_addr + 1);
	endtask

	task automatic read_back();
		size_check <= 1'b1;
		foreach (written[i]) begin
			cart_addr <= written[i];
			rd_want <= model[written[i]];
			rd_req <= 1'b1;
			@(posedge clk_sys);
			reads_done++;
		end
		rd_req <= 1'b0;
		idle(2);
		size_check <= 1'b0;
	endtask

	task automatic drive_joysticks(input int n);
		repeat (n) begin
			joystick_0 <= next_random();
			joystick_1 <= next_random();
			if (next_random() % 4 == 0)
				joyswap <= ~joyswap;
			@(posedge clk_sys);
		end
	endtask

	// Six lines of 28 pixels, vs high for the first line
	task automatic drive_frame(input scan_t s);
		logic [31:0] rnd;
		scanlines <= s;
		for (int row = 0; row < 6; row++) begin
			for (int col = 0; col < 28; col++) begin
				rnd = next_random();
				hs <= (col < 4);
				vs <= (row == 0);
				de <= (col >= 4) && (rnd[26:24] != 3'd0);
				r <= rnd[7:0];
				g <= rnd[15:8];
				b <= rnd[23:16];
				@(posedge clk_sys);
			end
		end
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES)
			@(posedge clk_sys);
		report_problem("run did not finish before the cycle limit");
		print_counts();
		$display("Test failed");
		$finish;
	end

	initial begin
		rng = 32'hb9db;
		arst_n = 1'b0;
		pll_locked = 1'b0;
		reset_req = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		cart_addr = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		joyswap = 1'b0;
		r = '0;
		g = '0;
		b = '0;
		hs = 1'b0;
		vs = 1'b0;
		de = 1'b0;
		scanlines = '0;
		audio = 16'h4000;   // Quarter density on the DAC for the whole run
		rd_req = 1'b0;
		rd_want = '0;
		size_check = 1'b0;
		exp_size = '0;
		repeat (10) @(posedge clk_sys);
		arst_n <= 1'b1;
		idle(20);
		pll_locked <= 1'b1;
		wait_core_run();
		idle(5);
		reset_req <= 1'b1;
		idle(3);
		reset_req <= 1'b0;
		wait_core_run();
		load_cart();
		read_back();
		wait_core_run();
		drive_joysticks(200);
		for (int s = 0; s < 4; s++)
			drive_frame(scan_t'(s));
		while (dac_cnt < 1030)
			@(posedge clk_sys);
		print_counts();
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- all.f
verilog/shell_pkg.sv
verilog/shell_ctrl.sv
verilog/cart_loader.sv
verilog/input_mapper.sv
verilog/scanline_video.sv
verilog/sigma_delta_dac.sv
verilog/console_shell.sv
verif/console_shell_tb.sv
